// ==== Makefile ====
VERILATOR  ?= verilator
TB_TOP     := rv_core_tb
RTL_TOP    := rv_core
FILELIST   := rv_core.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -j 0 -Mdir $(BUILD_DIR) --top-module $(TB_TOP)
LINT_FLAGS := --lint-only -Wall --top-module $(RTL_TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== logic/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core (
  input  wire                     clk,
  input  wire                     arst_n,
  output logic                    mem_req_valid,
  output rv_pkg::mem_req_t        mem_req,
  input  wire                     mem_req_ready,
  input  wire                     mem_resp_valid,
  input  wire rv_pkg::xlen_t      mem_resp_rdata,
  output logic                    commit_valid,
  output rv_pkg::commit_t         commit,
  output logic                    halted
);

  // Register file ports
  rv_pkg::reg_idx_t  gpr_raddr1;
  rv_pkg::reg_idx_t  gpr_raddr2;
  rv_pkg::xlen_t     gpr_rdata1;
  rv_pkg::xlen_t     gpr_rdata2;
  logic              gpr_wen;
  rv_pkg::reg_idx_t  gpr_waddr;
  rv_pkg::xlen_t     gpr_wdata;

  // Stage hand-offs
  logic              inst_valid;
  rv_pkg::inst_pkt_t inst;
  logic              inst_ready;
  logic              op_valid;
  rv_pkg::exec_op_t  op;
  logic              op_ready;
  logic              redirect_valid;
  rv_pkg::addr_t     redirect_pc;

  logic              lsu_valid;
  rv_pkg::lsu_req_t  lsu_req;
  logic              lsu_ready;
  logic              lsu_done;
  rv_pkg::xlen_t     lsu_rdata;

  // Arbiter side buses
  logic              imem_req_valid;
  rv_pkg::mem_req_t  imem_req;
  logic              imem_req_ready;
  logic              imem_resp_valid;
  rv_pkg::xlen_t     imem_resp_rdata;
  logic              dmem_req_valid;
  rv_pkg::mem_req_t  dmem_req;
  logic              dmem_req_ready;
  logic              dmem_resp_valid;
  rv_pkg::xlen_t     dmem_resp_rdata;

  rv_gpr u_gpr (
    .clk(clk), .arst_n(arst_n),
    .raddr1(gpr_raddr1), .raddr2(gpr_raddr2),
    .rdata1(gpr_rdata1), .rdata2(gpr_rdata2),
    .wen(gpr_wen), .waddr(gpr_waddr), .wdata(gpr_wdata)
  );

  rv_fetch u_fetch (
    .clk(clk), .arst_n(arst_n),
    .imem_req_valid(imem_req_valid), .imem_req(imem_req),
    .imem_req_ready(imem_req_ready),
    .imem_resp_valid(imem_resp_valid), .imem_resp_rdata(imem_resp_rdata),
    .inst_valid(inst_valid), .inst(inst), .inst_ready(inst_ready),
    .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
    .halt(halted)
  );

  rv_decode u_decode (
    .inst_valid(inst_valid), .inst(inst), .inst_ready(inst_ready),
    .gpr_raddr1(gpr_raddr1), .gpr_raddr2(gpr_raddr2),
    .gpr_rdata1(gpr_rdata1), .gpr_rdata2(gpr_rdata2),
    .op_valid(op_valid), .op(op), .op_ready(op_ready)
  );

  rv_execute u_execute (
    .clk(clk), .arst_n(arst_n),
    .op_valid(op_valid), .op(op), .op_ready(op_ready),
    .lsu_valid(lsu_valid), .lsu_req(lsu_req), .lsu_ready(lsu_ready),
    .lsu_done(lsu_done), .lsu_rdata(lsu_rdata),
    .gpr_wen(gpr_wen), .gpr_waddr(gpr_waddr), .gpr_wdata(gpr_wdata),
    .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
    .commit_valid(commit_valid), .commit(commit), .halted(halted)
  );

  rv_lsu u_lsu (
    .clk(clk), .arst_n(arst_n),
    .lsu_valid(lsu_valid), .lsu_req(lsu_req), .lsu_ready(lsu_ready),
    .lsu_done(lsu_done), .lsu_rdata(lsu_rdata),
    .dmem_req_valid(dmem_req_valid), .dmem_req(dmem_req),
    .dmem_req_ready(dmem_req_ready),
    .dmem_resp_valid(dmem_resp_valid), .dmem_resp_rdata(dmem_resp_rdata)
  );

  rv_mem_arb u_mem_arb (
    .clk(clk), .arst_n(arst_n),
    .fetch_req_valid(imem_req_valid), .fetch_req(imem_req),
    .fetch_req_ready(imem_req_ready),
    .fetch_resp_valid(imem_resp_valid), .fetch_resp_rdata(imem_resp_rdata),
    .data_req_valid(dmem_req_valid), .data_req(dmem_req),
    .data_req_ready(dmem_req_ready),
    .data_resp_valid(dmem_resp_valid), .data_resp_rdata(dmem_resp_rdata),
    .mem_req_valid(mem_req_valid), .mem_req(mem_req),
    .mem_req_ready(mem_req_ready),
    .mem_resp_valid(mem_resp_valid), .mem_resp_rdata(mem_resp_rdata)
  );

endmodule

`default_nettype wire

// ==== logic/rv_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
  input  wire                     inst_valid,
  input  wire rv_pkg::inst_pkt_t  inst,
  output logic                    inst_ready,
  output rv_pkg::reg_idx_t        gpr_raddr1,
  output rv_pkg::reg_idx_t        gpr_raddr2,
  input  wire rv_pkg::xlen_t      gpr_rdata1,
  input  wire rv_pkg::xlen_t      gpr_rdata2,
  output logic                    op_valid,
  output rv_pkg::exec_op_t        op,
  input  wire                     op_ready
);

  rv_pkg::xlen_t    iw;
  rv_pkg::opcode_t  opcode;
  rv_pkg::reg_idx_t rd;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  rv_pkg::xlen_t    imm_i;
  rv_pkg::xlen_t    imm_s;
  rv_pkg::xlen_t    imm_b;
  rv_pkg::xlen_t    imm_u;
  rv_pkg::xlen_t    imm_j;
  logic             wb;

  assign iw     = inst.inst;
  assign opcode = iw[6:0];
  assign rd     = iw[11:7];
  assign funct3 = iw[14:12];
  assign funct7 = iw[31:25];

  assign gpr_raddr1 = iw[19:15];
  assign gpr_raddr2 = iw[24:20];

  assign imm_i = {{20{iw[31]}}, iw[31:20]};
  assign imm_s = {{20{iw[31]}}, iw[31:25], iw[11:7]};
  assign imm_b = {{19{iw[31]}}, iw[31], iw[7], iw[30:25], iw[11:8], 1'b0};
  assign imm_u = {iw[31:12], 12'b0};
  assign imm_j = {{11{iw[31]}}, iw[31], iw[19:12], iw[20], iw[30:21], 1'b0};

  always_comb begin
    op.pc        = inst.pc;
    op.a         = gpr_rdata1;
    op.b         = imm_i;
    op.rs2_val   = gpr_rdata2;
    op.imm       = imm_i;
    op.rd        = rd;
    op.alu_op    = rv_pkg::alu_add;
    op.is_load   = 1'b0;
    op.is_store  = 1'b0;
    op.is_branch = 1'b0;
    op.branch_ne = 1'b0;
    op.is_jal    = 1'b0;
    op.is_halt   = 1'b0;
    wb           = 1'b0;
    case (opcode)
      rv_pkg::OP_LUI: begin
        op.a      = '0;
        op.b      = imm_u;
        op.alu_op = rv_pkg::alu_pass_b;
        wb        = 1'b1;
      end
      rv_pkg::OP_IMM: begin
        wb = (funct3 == rv_pkg::F3_ADD);
      end
      rv_pkg::OP_REG: begin
        op.b = gpr_rdata2;
        if (funct3 == rv_pkg::F3_ADD && funct7 == rv_pkg::F7_SUB) begin
          op.alu_op = rv_pkg::alu_sub;
        end
        wb = (funct3 == rv_pkg::F3_ADD) &&
             (funct7 == rv_pkg::F7_ADD || funct7 == rv_pkg::F7_SUB);
      end
      rv_pkg::OP_LOAD: begin
        op.is_load = (funct3 == rv_pkg::F3_W);
        wb         = op.is_load;
      end
      rv_pkg::OP_STORE: begin
        op.b        = imm_s;
        op.imm      = imm_s;
        op.is_store = (funct3 == rv_pkg::F3_W);
      end
      rv_pkg::OP_BRANCH: begin
        // Equality test on the difference
        op.b         = gpr_rdata2;
        op.imm       = imm_b;
        op.alu_op    = rv_pkg::alu_sub;
        op.is_branch = (funct3 == rv_pkg::F3_BEQ || funct3 == rv_pkg::F3_BNE);
        op.branch_ne = (funct3 == rv_pkg::F3_BNE);
      end
      rv_pkg::OP_JAL: begin
        op.a      = inst.pc;
        op.b      = imm_j;
        op.imm    = imm_j;
        op.is_jal = 1'b1;
        wb        = 1'b1;
      end
      rv_pkg::OP_SYSTEM: begin
        op.is_halt = (iw == rv_pkg::INST_EBREAK);
      end
      default: begin
        wb = 1'b0;
      end
    endcase
    // No architectural write for rd == x0
    op.wb_en = wb && (rd != '0);
  end

  assign op_valid   = inst_valid;
  assign inst_ready = op_ready;

endmodule

`default_nettype wire

// ==== logic/rv_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
  input  wire                     clk,
  input  wire                     arst_n,
  input  wire                     op_valid,
  input  wire rv_pkg::exec_op_t   op,
  output logic                    op_ready,
  output logic                    lsu_valid,
  output rv_pkg::lsu_req_t        lsu_req,
  input  wire                     lsu_ready,
  input  wire                     lsu_done,
  input  wire rv_pkg::xlen_t      lsu_rdata,
  output logic                    gpr_wen,
  output rv_pkg::reg_idx_t        gpr_waddr,
  output rv_pkg::xlen_t           gpr_wdata,
  output logic                    redirect_valid,
  output rv_pkg::addr_t           redirect_pc,
  output logic                    commit_valid,
  output rv_pkg::commit_t         commit,
  output logic                    halted
);

  rv_pkg::exec_state_e state;
  rv_pkg::xlen_t       alu_res;
  rv_pkg::xlen_t       wb_data;
  rv_pkg::addr_t       pc_plus4;
  rv_pkg::addr_t       next_pc;
  logic                op_fire;
  logic                is_mem;
  logic                taken;
  logic                in_lsu;

  always_comb begin
    case (op.alu_op)
      rv_pkg::alu_sub:    alu_res = op.a - op.b;
      rv_pkg::alu_pass_b: alu_res = op.b;
      default:            alu_res = op.a + op.b;
    endcase
  end

  assign pc_plus4 = op.pc + 32'd4;
  assign taken    = op.is_jal || (op.is_branch && ((alu_res == '0) != op.branch_ne));
  assign next_pc  = taken ? op.pc + op.imm : pc_plus4;
  assign wb_data  = op.is_jal ? pc_plus4 : alu_res;
  assign is_mem   = op.is_load || op.is_store;

  assign op_ready = (state == rv_pkg::exec_run) && !halted;
  assign op_fire  = op_valid && op_ready;
  assign in_lsu   = (state == rv_pkg::exec_wait_lsu);

  // Loads write back when the data returns
  assign gpr_wen   = (op_fire && op.wb_en && !is_mem) || (in_lsu && lsu_done && commit.wb_en);
  assign gpr_waddr = in_lsu ? commit.rd : op.rd;
  assign gpr_wdata = in_lsu ? lsu_rdata : wb_data;

  assign redirect_valid = commit_valid;
  assign redirect_pc    = commit.next_pc;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state        <= rv_pkg::exec_run;
      lsu_valid    <= 1'b0;
      commit_valid <= 1'b0;
      halted       <= 1'b0;
    end else begin
      commit_valid <= 1'b0;
      if (lsu_valid && lsu_ready) begin
        lsu_valid <= 1'b0;
      end
      case (state)
        rv_pkg::exec_run: begin
          if (op_fire && is_mem) begin
            lsu_valid <= 1'b1;
            state     <= rv_pkg::exec_wait_lsu;
          end else if (op_fire) begin
            commit_valid <= 1'b1;
            halted       <= op.is_halt;
          end
        end
        default: begin
          if (lsu_done) begin
            commit_valid <= 1'b1;
            state        <= rv_pkg::exec_run;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (op_fire) begin
      commit.pc      <= op.pc;
      commit.next_pc <= next_pc;
      commit.rd      <= op.rd;
      commit.wb_en   <= op.wb_en;
      commit.wdata   <= wb_data;
      lsu_req.addr   <= alu_res;
      lsu_req.we     <= op.is_store;
      lsu_req.wdata  <= op.rs2_val;
    end else if (in_lsu && lsu_done && commit.wb_en) begin
      commit.wdata <= lsu_rdata;
    end
  end

endmodule

`default_nettype wire

// ==== logic/rv_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_fetch (
  input  wire                     clk,
  input  wire                     arst_n,
  output logic                    imem_req_valid,
  output rv_pkg::mem_req_t        imem_req,
  input  wire                     imem_req_ready,
  input  wire                     imem_resp_valid,
  input  wire rv_pkg::xlen_t      imem_resp_rdata,
  output logic                    inst_valid,
  output rv_pkg::inst_pkt_t       inst,
  input  wire                     inst_ready,
  input  wire                     redirect_valid,
  input  wire rv_pkg::addr_t      redirect_pc,
  input  wire                     halt
);

  rv_pkg::fetch_state_e state;
  rv_pkg::addr_t        pc;
  rv_pkg::xlen_t        inst_q;
  logic                 req_pend;
  logic                 boot;

  assign imem_req_valid = (state == rv_pkg::fetch_wait_resp) && req_pend;
  assign imem_req.addr  = pc;
  assign imem_req.we    = 1'b0;
  assign imem_req.wdata = '0;

  assign inst_valid = (state == rv_pkg::fetch_hold);
  assign inst.pc    = pc;
  assign inst.inst  = inst_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= rv_pkg::fetch_idle;
      pc       <= rv_pkg::RESET_PC;
      req_pend <= 1'b0;
      boot     <= 1'b1;
    end else begin
      case (state)
        rv_pkg::fetch_idle: begin
          // First fetch needs no redirect
          if (boot || redirect_valid) begin
            boot <= 1'b0;
            if (redirect_valid) begin
              pc <= redirect_pc;
            end
            if (!halt) begin
              req_pend <= 1'b1;
              state    <= rv_pkg::fetch_wait_resp;
            end
          end
        end
        rv_pkg::fetch_wait_resp: begin
          if (imem_req_valid && imem_req_ready) begin
            req_pend <= 1'b0;
          end
          if (imem_resp_valid) begin
            state <= rv_pkg::fetch_hold;
          end
        end
        default: begin
          if (inst_ready) begin
            state <= rv_pkg::fetch_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == rv_pkg::fetch_wait_resp && imem_resp_valid) begin
      inst_q <= imem_resp_rdata;
    end
  end

endmodule

`default_nettype wire

// ==== logic/rv_gpr.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_gpr (
  input  wire                     clk,
  input  wire                     arst_n,
  input  wire rv_pkg::reg_idx_t   raddr1,
  input  wire rv_pkg::reg_idx_t   raddr2,
  output rv_pkg::xlen_t           rdata1,
  output rv_pkg::xlen_t           rdata2,
  input  wire                     wen,
  input  wire rv_pkg::reg_idx_t   waddr,
  input  wire rv_pkg::xlen_t      wdata
);

  rv_pkg::xlen_t regs [32];

  // x0 is never written so it keeps its reset value
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

// ==== logic/rv_lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_lsu (
  input  wire                     clk,
  input  wire                     arst_n,
  input  wire                     lsu_valid,
  input  wire rv_pkg::lsu_req_t   lsu_req,
  output logic                    lsu_ready,
  output logic                    lsu_done,
  output rv_pkg::xlen_t           lsu_rdata,
  output logic                    dmem_req_valid,
  output rv_pkg::mem_req_t        dmem_req,
  input  wire                     dmem_req_ready,
  input  wire                     dmem_resp_valid,
  input  wire rv_pkg::xlen_t      dmem_resp_rdata
);

  rv_pkg::lsu_req_t req_q;
  logic             busy;

  assign lsu_ready = !busy;

  // Word accesses only
  assign dmem_req.addr  = {req_q.addr[31:2], 2'b00};
  assign dmem_req.we    = req_q.we;
  assign dmem_req.wdata = req_q.wdata;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy           <= 1'b0;
      dmem_req_valid <= 1'b0;
      lsu_done       <= 1'b0;
    end else begin
      lsu_done <= 1'b0;
      if (lsu_valid && lsu_ready) begin
        busy           <= 1'b1;
        dmem_req_valid <= 1'b1;
      end
      if (dmem_req_valid && dmem_req_ready) begin
        dmem_req_valid <= 1'b0;
      end
      if (busy && dmem_resp_valid) begin
        busy     <= 1'b0;
        lsu_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (lsu_valid && lsu_ready) begin
      req_q <= lsu_req;
    end
    if (busy && dmem_resp_valid) begin
      lsu_rdata <= dmem_resp_rdata;
    end
  end

endmodule

`default_nettype wire

// ==== logic/rv_mem_arb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_mem_arb (
  input  wire                     clk,
  input  wire                     arst_n,
  input  wire                     fetch_req_valid,
  input  wire rv_pkg::mem_req_t   fetch_req,
  output logic                    fetch_req_ready,
  output logic                    fetch_resp_valid,
  output rv_pkg::xlen_t           fetch_resp_rdata,
  input  wire                     data_req_valid,
  input  wire rv_pkg::mem_req_t   data_req,
  output logic                    data_req_ready,
  output logic                    data_resp_valid,
  output rv_pkg::xlen_t           data_resp_rdata,
  output logic                    mem_req_valid,
  output rv_pkg::mem_req_t        mem_req,
  input  wire                     mem_req_ready,
  input  wire                     mem_resp_valid,
  input  wire rv_pkg::xlen_t      mem_resp_rdata
);

  rv_pkg::arb_state_e state;
  logic               idle;
  logic               sel_data;
  logic               hold_q;
  logic               hold_data_q;

  // A stalled request keeps its grant until accepted
  assign idle     = (state == rv_pkg::arb_idle);
  assign sel_data = hold_q ? hold_data_q : data_req_valid;

  assign mem_req_valid   = idle && (data_req_valid || fetch_req_valid);
  assign mem_req         = sel_data ? data_req : fetch_req;
  assign data_req_ready  = idle && sel_data && mem_req_ready;
  assign fetch_req_ready = idle && !sel_data && mem_req_ready;

  assign fetch_resp_valid = (state == rv_pkg::arb_busy_fetch) && mem_resp_valid;
  assign data_resp_valid  = (state == rv_pkg::arb_busy_data) && mem_resp_valid;
  assign fetch_resp_rdata = mem_resp_rdata;
  assign data_resp_rdata  = mem_resp_rdata;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state       <= rv_pkg::arb_idle;
      hold_q      <= 1'b0;
      hold_data_q <= 1'b0;
    end else if (idle) begin
      hold_q      <= mem_req_valid && !mem_req_ready;
      hold_data_q <= sel_data;
      if (mem_req_valid && mem_req_ready && sel_data) begin
        state <= rv_pkg::arb_busy_data;
      end else if (mem_req_valid && mem_req_ready) begin
        state <= rv_pkg::arb_busy_fetch;
      end
    end else if (mem_resp_valid) begin
      state <= rv_pkg::arb_idle;
    end
  end

endmodule

`default_nettype wire

// ==== logic/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [6:0]  opcode_t;

  localparam addr_t RESET_PC = 32'h0000_0000;

  // Base opcodes
  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_IMM    = 7'b0010011;
  localparam opcode_t OP_REG    = 7'b0110011;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_SYSTEM = 7'b1110011;

  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_W   = 3'b010;
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [6:0] F7_ADD = 7'h00;
  localparam logic [6:0] F7_SUB = 7'h20;
  localparam xlen_t INST_EBREAK = 32'h0010_0073;

  typedef enum logic [1:0] {alu_add, alu_sub, alu_pass_b} alu_op_e;

  typedef enum logic [1:0] {fetch_idle, fetch_wait_resp, fetch_hold} fetch_state_e;
  typedef enum logic {exec_run, exec_wait_lsu} exec_state_e;
  typedef enum logic [1:0] {arb_idle, arb_busy_fetch, arb_busy_data} arb_state_e;

  typedef struct packed {
    addr_t addr;
    logic  we;
    xlen_t wdata;
  } mem_req_t;

  typedef struct packed {
    addr_t pc;
    xlen_t inst;
  } inst_pkt_t;

  typedef struct packed {
    addr_t    pc;
    xlen_t    a;
    xlen_t    b;
    xlen_t    rs2_val;
    xlen_t    imm;
    reg_idx_t rd;
    alu_op_e  alu_op;
    logic     is_load;
    logic     is_store;
    logic     is_branch;
    logic     branch_ne;
    logic     is_jal;
    logic     wb_en;
    logic     is_halt;
  } exec_op_t;

  typedef struct packed {
    addr_t addr;
    logic  we;
    xlen_t wdata;
  } lsu_req_t;

  typedef struct packed {
    addr_t    pc;
    addr_t    next_pc;
    reg_idx_t rd;
    logic     wb_en;
    xlen_t    wdata;
  } commit_t;

endpackage

`default_nettype wire

// ==== rv_core.f ====
logic/rv_pkg.sv
logic/rv_gpr.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_lsu.sv
logic/rv_mem_arb.sv
logic/rv_core.sv
sim/rv_core_tb.sv

// ==== sim/rv_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

  localparam int MAX_INSTS       = 200;
  localparam int CYCLES_PER_INST = 20;
  localparam int CYCLE_LIMIT     = MAX_INSTS * CYCLES_PER_INST;
  localparam int HALT_WATCH      = 50;

  logic               clk;
  logic               arst_n;
  logic               mem_req_valid;
  rv_pkg::mem_req_t   mem_req;
  logic               mem_req_ready;
  logic               mem_resp_valid;
  rv_pkg::xlen_t      mem_resp_rdata;
  logic               commit_valid;
  rv_pkg::commit_t    commit;
  logic               halted;

  // Memory model and its bookkeeping
  rv_pkg::xlen_t      mem [1024];
  integer             seed;
  logic               outstanding;
  logic               resp_pending;
  int                 resp_wait;
  rv_pkg::xlen_t      resp_data;
  logic               held_valid;
  rv_pkg::mem_req_t   held_req;
  int                 requests;

  // Instruction-set model state
  rv_pkg::xlen_t      ref_mem [1024];
  rv_pkg::xlen_t      ref_regs [32];
  rv_pkg::addr_t      ref_pc;
  logic               model_halted;
  rv_pkg::addr_t      prev_next_pc;
  int                 expected_count;
  int                 data_accesses;
  int                 commits;
  int                 cycles;
  int                 halt_cycles;
  logic               halt_seen;

  rv_core u_rv_core (
    .clk(clk), .arst_n(arst_n),
    .mem_req_valid(mem_req_valid), .mem_req(mem_req), .mem_req_ready(mem_req_ready),
    .mem_resp_valid(mem_resp_valid), .mem_resp_rdata(mem_resp_rdata),
    .commit_valid(commit_valid), .commit(commit), .halted(halted)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic abort_sim();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic require(input logic ok, input string what);
    assert (ok) else begin
      $display("ERROR at %0t: %s", $time, what);
      abort_sim();
    end
  endtask

  task automatic compare(input string name, input rv_pkg::xlen_t got,
                         input rv_pkg::xlen_t expected);
    assert (got === expected) else begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, expected);
      abort_sim();
    end
  endtask

  // RV32I instruction formats
  function automatic rv_pkg::xlen_t r_type(input int f7, input int f3, input int rd,
                                           input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], rv_pkg::OP_REG};
  endfunction

  function automatic rv_pkg::xlen_t i_type(input rv_pkg::opcode_t opc, input int f3,
                                           input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic rv_pkg::xlen_t s_type(input int f3, input int rs1, input int rs2,
                                           input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], rv_pkg::OP_STORE};
  endfunction

  function automatic rv_pkg::xlen_t b_type(input int f3, input int rs1, input int rs2,
                                           input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
            rv_pkg::OP_BRANCH};
  endfunction

  function automatic rv_pkg::xlen_t u_type(input rv_pkg::opcode_t opc, input int rd,
                                           input int imm);
    return {imm[19:0], rd[4:0], opc};
  endfunction

  function automatic rv_pkg::xlen_t j_type(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv_pkg::OP_JAL};
  endfunction

  task automatic load_program();
    for (int i = 0; i < 1024; i++) begin
      mem[i] = (i * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    end
    mem[0]  = u_type(rv_pkg::OP_LUI, 1, 'h12345);
    mem[1]  = i_type(rv_pkg::OP_IMM, 0, 1, 1, 'h678);
    mem[2]  = i_type(rv_pkg::OP_IMM, 0, 2, 0, -5);
    mem[3]  = r_type(0, 0, 3, 1, 2);
    mem[4]  = r_type(32, 0, 4, 1, 2);
    // Write to x0 and read it back later
    mem[5]  = i_type(rv_pkg::OP_IMM, 0, 0, 0, 7);
    mem[6]  = r_type(0, 0, 5, 0, 3);
    mem[7]  = i_type(rv_pkg::OP_IMM, 0, 6, 0, 'h400);
    mem[8]  = s_type(2, 6, 3, 0);
    mem[9]  = i_type(rv_pkg::OP_LOAD, 2, 7, 6, 0);
    mem[10] = s_type(2, 6, 4, 8);
    mem[11] = i_type(rv_pkg::OP_LOAD, 2, 8, 6, 8);
    mem[12] = i_type(rv_pkg::OP_IMM, 0, 9, 0, 5);
    mem[13] = i_type(rv_pkg::OP_IMM, 0, 10, 0, 0);
    // Loop body runs five times
    mem[14] = r_type(0, 0, 10, 10, 9);
    mem[15] = s_type(2, 6, 10, 4);
    mem[16] = i_type(rv_pkg::OP_LOAD, 2, 11, 6, 4);
    mem[17] = i_type(rv_pkg::OP_IMM, 0, 9, 9, -1);
    mem[18] = b_type(1, 9, 0, -16);
    mem[19] = b_type(0, 10, 11, 8);
    mem[20] = i_type(rv_pkg::OP_IMM, 0, 12, 0, 1);
    mem[21] = b_type(0, 10, 0, 8);
    mem[22] = j_type(13, 8);
    mem[23] = i_type(rv_pkg::OP_IMM, 0, 12, 0, 2);
    mem[24] = j_type(0, 8);
    mem[25] = i_type(rv_pkg::OP_IMM, 0, 12, 0, 3);
    // AND is not supported and retires as a no-op
    mem[26] = r_type(0, 7, 14, 1, 2);
    mem[27] = i_type(rv_pkg::OP_LOAD, 2, 14, 6, 0);
    mem[28] = r_type(0, 0, 15, 14, 7);
    mem[29] = i_type(rv_pkg::OP_SYSTEM, 0, 0, 0, 1);
  endtask

  task automatic reset_model();
    for (int i = 0; i < 1024; i++) begin
      ref_mem[i] = mem[i];
    end
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    ref_pc       = rv_pkg::RESET_PC;
    model_halted = 1'b0;
  endtask

  task automatic iss_step(output rv_pkg::addr_t pc, output rv_pkg::addr_t npc,
                          output logic wb, output logic [4:0] rd,
                          output rv_pkg::xlen_t wdata, output logic halt);
    rv_pkg::xlen_t iw;
    rv_pkg::xlen_t a;
    rv_pkg::xlen_t b;
    rv_pkg::xlen_t imm_i;
    rv_pkg::xlen_t imm_s;
    rv_pkg::xlen_t imm_b;
    rv_pkg::xlen_t imm_j;
    rv_pkg::addr_t ea;
    logic [2:0]    f3;
    logic [6:0]    f7;
    iw    = ref_mem[ref_pc[11:2]];
    f3    = iw[14:12];
    f7    = iw[31:25];
    rd    = iw[11:7];
    a     = ref_regs[iw[19:15]];
    b     = ref_regs[iw[24:20]];
    imm_i = {{20{iw[31]}}, iw[31:20]};
    imm_s = {{20{iw[31]}}, iw[31:25], iw[11:7]};
    imm_b = {{20{iw[31]}}, iw[7], iw[30:25], iw[11:8], 1'b0};
    imm_j = {{12{iw[31]}}, iw[19:12], iw[20], iw[30:21], 1'b0};
    pc    = ref_pc;
    npc   = ref_pc + 32'd4;
    wb    = 1'b0;
    wdata = '0;
    halt  = 1'b0;
    case (iw[6:0])
      rv_pkg::OP_LUI: begin
        wb    = 1'b1;
        wdata = {iw[31:12], 12'b0};
      end
      rv_pkg::OP_IMM: begin
        wb    = (f3 == 3'd0);
        wdata = a + imm_i;
      end
      rv_pkg::OP_REG: begin
        wb    = (f3 == 3'd0) && (f7 == 7'h00 || f7 == 7'h20);
        wdata = (f7 == 7'h20) ? a - b : a + b;
      end
      rv_pkg::OP_LOAD: begin
        ea    = a + imm_i;
        wb    = (f3 == 3'd2);
        wdata = ref_mem[ea[11:2]];
      end
      rv_pkg::OP_STORE: begin
        ea = a + imm_s;
        if (f3 == 3'd2) begin
          ref_mem[ea[11:2]] = b;
        end
      end
      rv_pkg::OP_BRANCH: begin
        if ((f3 == 3'd0 && a == b) || (f3 == 3'd1 && a != b)) begin
          npc = ref_pc + imm_b;
        end
      end
      rv_pkg::OP_JAL: begin
        wb    = 1'b1;
        wdata = ref_pc + 32'd4;
        npc   = ref_pc + imm_j;
      end
      rv_pkg::OP_SYSTEM: begin
        halt = (iw == 32'h0010_0073);
      end
      default: begin
        wb = 1'b0;
      end
    endcase
    if (rd == 5'd0) begin
      wb = 1'b0;
    end
    if (wb) begin
      ref_regs[rd] = wdata;
    end
    ref_pc = npc;
  endtask

  task automatic sample_bus();
    logic [9:0] idx;
    if (held_valid) begin
      require(mem_req_valid === 1'b1, "mem_req_valid dropped before it was accepted");
      compare("mem_req.addr", mem_req.addr, held_req.addr);
      compare("mem_req.we", {31'b0, mem_req.we}, {31'b0, held_req.we});
      compare("mem_req.wdata", mem_req.wdata, held_req.wdata);
    end
    require(!(mem_req_valid === 1'b1 && outstanding),
            "new request while a response is still outstanding");
    if (mem_resp_valid) begin
      outstanding = 1'b0;
    end
    held_valid = (mem_req_valid === 1'b1) && !mem_req_ready;
    held_req   = mem_req;
    if (mem_req_valid === 1'b1 && mem_req_ready) begin
      require(mem_req.addr[31:12] == '0 && mem_req.addr[1:0] == '0,
              "request address outside memory or not word aligned");
      idx          = mem_req.addr[11:2];
      outstanding  = 1'b1;
      resp_pending = 1'b1;
      resp_wait    = $unsigned($random(seed)) % 4;
      requests++;
      if (mem_req.we) begin
        mem[idx]  = mem_req.wdata;
        resp_data = '0;
      end else begin
        resp_data = mem[idx];
      end
    end
  endtask

  task automatic drive_memory();
    mem_resp_valid = 1'b0;
    if (resp_pending) begin
      if (resp_wait == 0) begin
        mem_resp_valid = 1'b1;
        mem_resp_rdata = resp_data;
        resp_pending   = 1'b0;
      end else begin
        resp_wait--;
      end
    end
    mem_req_ready = ($unsigned($random(seed)) % 4) != 0;
  endtask

  task automatic verify_commit();
    rv_pkg::addr_t pc;
    rv_pkg::addr_t npc;
    logic          wb;
    logic [4:0]    rd;
    rv_pkg::xlen_t wdata;
    logic          halt;
    if (commit_valid) begin
      require(!model_halted, "commit after EBREAK retired");
      iss_step(pc, npc, wb, rd, wdata, halt);
      compare("commit.pc (previous next_pc)", commit.pc, prev_next_pc);
      compare("commit.pc", commit.pc, pc);
      compare("commit.next_pc", commit.next_pc, npc);
      compare("commit.wb_en", {31'b0, commit.wb_en}, {31'b0, wb});
      if (wb) begin
        compare("commit.rd", {27'b0, commit.rd}, {27'b0, rd});
        compare("commit.wdata", commit.wdata, wdata);
      end
      compare("halted", {31'b0, halted}, {31'b0, halt});
      prev_next_pc = commit.next_pc;
      model_halted = halt;
      commits++;
    end
  endtask

  task automatic watch_halt();
    if (halt_seen) begin
      require(halted === 1'b1, "halted dropped after it was set");
      require(mem_req_valid !== 1'b1, "memory request issued after halt");
      halt_cycles++;
    end else if (halted === 1'b1) begin
      require(model_halted, "halted rose without an EBREAK commit");
      halt_seen = 1'b1;
    end
  endtask

  task automatic conclude();
    if (commits == expected_count && requests == expected_count + data_accesses) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("ERROR at %0t: %0d commits for %0d expected, %0d bus requests for %0d expected",
               $time, commits, expected_count, requests, expected_count + data_accesses);
      abort_sim();
    end
  endtask

  initial begin
    rv_pkg::addr_t pc;
    rv_pkg::addr_t npc;
    logic          wb;
    logic [4:0]    rd;
    rv_pkg::xlen_t wdata;
    logic          halt;
    rv_pkg::xlen_t iw;
    seed           = 32'h6ecafc77;
    arst_n         = 1'b0;
    mem_req_ready  = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp_rdata = '0;
    outstanding    = 1'b0;
    resp_pending   = 1'b0;
    resp_wait      = 0;
    resp_data      = '0;
    held_valid     = 1'b0;
    held_req       = '0;
    requests       = 0;
    commits        = 0;
    cycles         = 0;
    halt_cycles    = 0;
    halt_seen      = 1'b0;
    prev_next_pc   = rv_pkg::RESET_PC;
    load_program();
    // Dry run gives the instruction count up to EBREAK and the word accesses
    reset_model();
    expected_count = 0;
    data_accesses  = 0;
    while (!model_halted) begin
      iw = ref_mem[ref_pc[11:2]];
      if ((iw[6:0] == rv_pkg::OP_LOAD || iw[6:0] == rv_pkg::OP_STORE) &&
          iw[14:12] == 3'd2) begin
        data_accesses++;
      end
      iss_step(pc, npc, wb, rd, wdata, halt);
      model_halted = halt;
      expected_count++;
      require(expected_count <= MAX_INSTS, "program does not reach EBREAK");
    end
    reset_model();
    for (int i = 0; i < 16; i++) begin
      @(posedge clk);
      if (i > 0) begin
        require(commit_valid === 1'b0, "commit_valid high during reset");
        require(halted === 1'b0, "halted high during reset");
        require(mem_req_valid === 1'b0, "mem_req_valid high during reset");
      end
    end
    #2;
    arst_n = 1'b1;
  end

  always @(posedge clk) begin
    if (arst_n) begin
      cycles++;
      require(cycles < CYCLE_LIMIT, "timeout, the core did not halt in time");
      if (cycles == 2) begin
        require(mem_req_valid === 1'b1, "no fetch request in the first cycle after reset");
      end
      sample_bus();
      verify_commit();
      watch_halt();
      if (halt_cycles == HALT_WATCH) begin
        conclude();
      end else begin
        #2;
        drive_memory();
      end
    end
  end

endmodule

`default_nettype wire
